// File: sources.f
rtl/lane_fpu_pkg.sv
rtl/lane_op_if.sv
rtl/fpu_ctrl_apb.sv
rtl/fpu_issue_stage.sv
rtl/fpu_lane_exec.sv
rtl/fpu_lane_merge.sv
rtl/meta_fpu_top.sv
verif/meta_fpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the lane FPU testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module meta_fpu_tb -o meta_fpu_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/meta_fpu_sim > sim.log 2>&1
cat sim.log

grep -q "Verification failed" sim.log && exit 1 || grep -q "Verification passed" sim.log || exit 1
exit 0

// File: verif/meta_fpu_tb.sv
// Lane FPU testbench
`timescale 1ns/1ps

module meta_fpu_tb;
	import lane_fpu_pkg::*;

	// Issued operations over all tests, sizes the watchdog
	localparam int NUM_OPS = 56;
	localparam int WATCHDOG_CYCLES = 400 + 3 * NUM_OPS;

	logic                  clk;
	logic                  arst_n_i;
	logic                  issue_valid;
	tag_t                  issue_tag;
	fop_e                  issue_opc;
	prec_e                 issue_prec;
	fdata_t                issue_a;
	fdata_t                issue_b;
	fdata_t                issue_t;
	stomp_t                stomp;
	logic [APB_ADDR_W-1:0] paddr;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [31:0]           pwdata;
	logic [31:0]           prdata;
	logic                  pready;
	logic                  pslverr;
	logic                  res_valid;
	tag_t                  res_tag;
	fdata_t                res_data;
	bytemask_t             res_we;
	logic                  res_exc;

	// Expected results in issue order, with the cycle each one is due
	tag_t      exp_tag_q[$];
	fdata_t    exp_data_q[$];
	logic      exp_exc_q[$];
	int        exp_cyc_q[$];
	bytemask_t shadow_mask = '0;
	logic      shadow_zfill = 1'b0;
	int        cyc = 0;

	meta_fpu_top dut0 (
		.clk(clk), .arst_n_i(arst_n_i),
		.issue_valid_i(issue_valid), .issue_tag_i(issue_tag), .issue_op_i(issue_opc),
		.issue_prec_i(issue_prec), .issue_a_i(issue_a), .issue_b_i(issue_b),
		.issue_t_i(issue_t), .stomp_i(stomp),
		.paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
		.res_valid_o(res_valid), .res_tag_o(res_tag), .res_data_o(res_data),
		.res_we_o(res_we), .res_exc_o(res_exc)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic report_fail(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "Run stopped");
	endtask

	// ==============================
	// Reference model
	// ==============================

	// Exponent all ones with a nonzero mantissa
	function automatic logic lane_is_nan(input fdata_t x, input int ew, input int mw);
		fdata_t exp_f;
		fdata_t man_f;
		exp_f = (x >> mw) & ((64'd1 << ew) - 1);
		man_f = x & ((64'd1 << mw) - 1);
		return (exp_f == ((64'd1 << ew) - 1)) && (man_f != 0);
	endfunction

	// True when x sits below y as a sign-magnitude number of width w
	function automatic logic smag_below(input fdata_t x, input fdata_t y, input int w);
		fdata_t mag_m;
		mag_m = (w == 64) ? 64'h7FFF_FFFF_FFFF_FFFF : ((64'd1 << (w - 1)) - 1);
		if (x[w-1] != y[w-1])
			return x[w-1];
		if (x[w-1])
			return (x & mag_m) > (y & mag_m);
		return (x & mag_m) < (y & mag_m);
	endfunction

	function automatic fdata_t expected_result(input fop_e op, input prec_e prec,
		input fdata_t a, input fdata_t b, input fdata_t t, input bytemask_t mask,
		input logic zf, output logic exc);
		int     w;
		int     ew;
		fdata_t lmask;
		fdata_t mag_m;
		fdata_t x;
		fdata_t y;
		fdata_t r;
		fdata_t res;
		logic   nan;
		case (prec)
			PREC_H: begin
				w = 16;
				ew = 5;
			end
			PREC_S: begin
				w = 32;
				ew = 8;
			end
			default: begin
				w = 64;
				ew = 11;
			end
		endcase
		lmask = (w == 64) ? '1 : ((64'd1 << w) - 1);
		mag_m = lmask >> 1;
		res = '0;
		exc = 1'b0;
		for (int l = 0; l < 64 / w; l++) begin
			x = (a >> (l * w)) & lmask;
			y = (b >> (l * w)) & lmask;
			nan = lane_is_nan(x, ew, w - 1 - ew) || lane_is_nan(y, ew, w - 1 - ew);
			case (op)
				FOP_NEG:  r = x ^ (lmask & ~mag_m);
				FOP_ABS:  r = x & mag_m;
				FOP_SGNJ: r = (x & mag_m) | (y & lmask & ~mag_m);
				FOP_MIN:  r = (!nan && smag_below(y, x, w)) ? y : x;
				FOP_MAX:  r = (!nan && smag_below(x, y, w)) ? y : x;
				default:  r = x;
			endcase
			if ((op == FOP_MIN || op == FOP_MAX) && nan)
				exc = 1'b1;
			res = res | ((r & lmask) << (l * w));
		end
		// Masked bytes show the target, or zero with zero-fill
		for (int i = 0; i < BYTES; i++)
			if (mask[i])
				res[i*8 +: 8] = zf ? 8'h00 : t[i*8 +: 8];
		return res;
	endfunction

	// ==============================
	// Stimulus tasks
	// ==============================
	function automatic void idle_inputs();
		issue_valid = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		stomp = '0;
	endfunction

	task automatic issue_op(input tag_t tag, input fop_e op, input prec_e prec,
		input fdata_t a, input fdata_t b, input fdata_t t, input bit keep);
		logic   exc;
		fdata_t res;
		@(negedge clk);
		idle_inputs();
		issue_valid = 1'b1;
		issue_tag = tag;
		issue_opc = op;
		issue_prec = prec;
		issue_a = a;
		issue_b = b;
		issue_t = t;
		res = expected_result(op, prec, a, b, t, shadow_mask, shadow_zfill, exc);
		// A stomped operation leaves nothing to expect
		if (keep) begin
			exp_tag_q.push_back(tag);
			exp_data_q.push_back(res);
			exp_exc_q.push_back(exc);
			exp_cyc_q.push_back(cyc + 3);
		end
	endtask

	task automatic issue_random(input tag_t tag, input fop_e op, input prec_e prec);
		issue_op(tag, op, prec, {$urandom, $urandom}, {$urandom, $urandom},
			{$urandom, $urandom}, 1'b1);
	endtask

	task automatic drain_results();
		@(negedge clk);
		idle_inputs();
		while (exp_tag_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic apb_access(input logic [APB_ADDR_W-1:0] addr, input logic wr,
		input logic [31:0] data, input logic exp_err);
		@(negedge clk);
		idle_inputs();
		psel = 1'b1;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		// Mid-cycle of the access phase, all responses have settled
		#25;
		assert (pready == 1'b1) else begin
			$display("[ERROR] pready_o got %h expected %h", pready, 1'b1);
			report_fail("pready_o was low in an access phase");
		end
		assert (pslverr == exp_err) else begin
			$display("[ERROR] pslverr_o got %h expected %h", pslverr, exp_err);
			report_fail("APB error response is wrong");
		end
		@(posedge clk);
		@(negedge clk);
		idle_inputs();
	endtask

	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic exp_err);
		apb_access(addr, 1'b1, data, exp_err);
		if (!exp_err && addr == REG_LANE_MASK)
			shadow_mask = data[BYTES-1:0];
		if (!exp_err && addr == REG_ZERO_FILL)
			shadow_zfill = data[0];
	endtask

	task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] exp_data,
		input logic exp_err);
		@(negedge clk);
		idle_inputs();
		psel = 1'b1;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		#25;
		assert (pslverr == exp_err) else begin
			$display("[ERROR] pslverr_o got %h expected %h", pslverr, exp_err);
			report_fail("APB error response is wrong");
		end
		assert (exp_err || prdata == exp_data) else begin
			$display("[ERROR] prdata_o got %h expected %h", prdata, exp_data);
			report_fail("APB read data is wrong");
		end
		@(negedge clk);
		idle_inputs();
	endtask

	// ==============================
	// Result monitor
	// ==============================
	always @(negedge clk) begin
		if (arst_n_i && res_valid) begin
			if (exp_tag_q.size() == 0)
				report_fail("A result came out with no operation outstanding");
			assert (res_tag == exp_tag_q[0]) else begin
				$display("[ERROR] res_tag_o got %h expected %h", res_tag, exp_tag_q[0]);
				report_fail("Result tag is wrong");
			end
			assert (res_data == exp_data_q[0]) else begin
				$display("[ERROR] res_data_o got %h expected %h", res_data, exp_data_q[0]);
				report_fail("Result data is wrong");
			end
			assert (res_we == 8'hFF) else begin
				$display("[ERROR] res_we_o got %h expected %h", res_we, 8'hFF);
				report_fail("Write enables are wrong");
			end
			assert (res_exc == exp_exc_q[0]) else begin
				$display("[ERROR] res_exc_o got %h expected %h", res_exc, exp_exc_q[0]);
				report_fail("Invalid flag is wrong");
			end
			assert (cyc == exp_cyc_q[0]) else
				report_fail("Result did not arrive three cycles after issue");
			void'(exp_tag_q.pop_front());
			void'(exp_data_q.pop_front());
			void'(exp_exc_q.pop_front());
			void'(exp_cyc_q.pop_front());
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		report_fail("Timeout, the tests did not finish within the cycle budget");
	end

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		int n;
		int r;
		int p;
		int o;
		void'($urandom(32'h5f32_058a));
		arst_n_i = 1'b0;
		idle_inputs();
		issue_tag = '0;
		issue_opc = FOP_NEG;
		issue_prec = PREC_H;
		issue_a = '0;
		issue_b = '0;
		issue_t = '0;
		paddr = '0;
		pwdata = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n_i = 1'b1;

		// All registers come out of reset as zero
		apb_read(REG_LANE_MASK, 32'h0, 1'b0);
		apb_read(REG_ZERO_FILL, 32'h0, 1'b0);
		apb_read(REG_EXC, 32'h0, 1'b0);

		// Sign operations back to back, three items in flight
		n = 0;
		for (r = 0; r < 4; r++)
			for (p = 0; p < 3; p++)
				for (o = 0; o < 3; o++) begin
					issue_random(tag_t'(n), fop_e'(o), prec_e'(p));
					n++;
				end
		drain_results();

		// Compares with signed zeros and mixed signs, no NaN anywhere
		issue_op(0, FOP_MIN, PREC_S, 64'h3F80_0000_8000_0000, 64'hBF80_0000_0000_0000, 0, 1);
		issue_op(1, FOP_MAX, PREC_S, 64'h3F80_0000_8000_0000, 64'hBF80_0000_0000_0000, 0, 1);
		issue_op(2, FOP_MIN, PREC_D, 64'h8000_0000_0000_0000, 64'h0, 0, 1);
		issue_op(3, FOP_MAX, PREC_D, 64'h8000_0000_0000_0000, 64'h0, 0, 1);
		issue_op(4, FOP_MIN, PREC_H, 64'hC000_4000_8000_0000, 64'h4000_C000_0000_8000, 0, 1);
		drain_results();
		apb_read(REG_EXC, 32'h0, 1'b0);
		// Half lane 0 of a is a NaN
		issue_op(5, FOP_MAX, PREC_H, 64'h3C00_3C00_3C00_7E01, {$urandom, $urandom}, 0, 1);
		drain_results();
		apb_read(REG_EXC, 32'h1, 1'b0);
		apb_write(REG_EXC, 32'h1, 1'b0);
		apb_read(REG_EXC, 32'h0, 1'b0);
		for (o = 0; o < 6; o++)
			issue_random(tag_t'(o), (o % 2) ? FOP_MAX : FOP_MIN, prec_e'(o % 3));
		drain_results();

		// Lane mask and zero-fill, sampled per operation at issue
		issue_random(0, FOP_ABS, PREC_D);
		apb_write(REG_LANE_MASK, 32'h0000_00F0, 1'b0);
		issue_random(1, FOP_NEG, PREC_S);
		apb_write(REG_ZERO_FILL, 32'h1, 1'b0);
		issue_random(2, FOP_SGNJ, PREC_H);
		issue_random(3, FOP_MIN, PREC_S);
		drain_results();
		apb_write(REG_LANE_MASK, 32'h0, 1'b0);
		apb_write(REG_ZERO_FILL, 32'h0, 1'b0);

		// Tag 6 is cancelled one cycle after it issued
		issue_random(5, FOP_NEG, PREC_D);
		issue_op(6, FOP_ABS, PREC_S, {$urandom, $urandom}, {$urandom, $urandom}, 0, 0);
		issue_random(7, FOP_SGNJ, PREC_H);
		stomp = 8'h40;
		drain_results();

		// Unmapped address 0xC while the exception flag is set
		issue_op(0, FOP_MIN, PREC_D, 64'h7FF0_0000_0000_0001, 64'h0, 0, 1);
		drain_results();
		apb_write(REG_LANE_MASK, 32'h0000_005A, 1'b0);
		apb_write(4'hC, 32'hFFFF_FFFF, 1'b1);
		apb_read(4'hC, 32'h0, 1'b1);
		apb_read(REG_LANE_MASK, 32'h0000_005A, 1'b0);
		apb_read(REG_ZERO_FILL, 32'h0, 1'b0);
		apb_read(REG_EXC, 32'h1, 1'b0);

		repeat (5) @(negedge clk);
		if (exp_tag_q.size() != 0)
			report_fail("Expected results were still outstanding at the end");
		else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

// File: rtl/meta_fpu_top.sv
// Lane FPU top level
`timescale 1ns/1ps

module meta_fpu_top (
	input  logic                                  clk,
	input  logic                                  arst_n_i,
	// Issue port
	input  logic                                  issue_valid_i,
	input  lane_fpu_pkg::tag_t                    issue_tag_i,
	input  lane_fpu_pkg::fop_e                    issue_op_i,
	input  lane_fpu_pkg::prec_e                   issue_prec_i,
	input  lane_fpu_pkg::fdata_t                  issue_a_i,
	input  lane_fpu_pkg::fdata_t                  issue_b_i,
	input  lane_fpu_pkg::fdata_t                  issue_t_i,
	input  lane_fpu_pkg::stomp_t                  stomp_i,
	// APB slave
	input  logic [lane_fpu_pkg::APB_ADDR_W-1:0]   paddr_i,
	input  logic                                  psel_i,
	input  logic                                  penable_i,
	input  logic                                  pwrite_i,
	input  logic [31:0]                           pwdata_i,
	output logic [31:0]                           prdata_o,
	output logic                                  pready_o,
	output logic                                  pslverr_o,
	// Result port
	output logic                                  res_valid_o,
	output lane_fpu_pkg::tag_t                    res_tag_o,
	output lane_fpu_pkg::fdata_t                  res_data_o,
	output lane_fpu_pkg::bytemask_t               res_we_o,
	output logic                                  res_exc_o
);
	import lane_fpu_pkg::*;

	bytemask_t lane_mask;
	logic      zero_fill;
	logic      exc_pulse;

	// Issue to exec, then exec to merge
	lane_op_if s1_if ();
	lane_op_if s2_if ();

	fpu_ctrl_apb u_ctrl (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.paddr_i     (paddr_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.pwdata_i    (pwdata_i),
		.exc_pulse_i (exc_pulse),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.lane_mask_o (lane_mask),
		.zero_fill_o (zero_fill)
	);

	fpu_issue_stage u_issue (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.issue_valid_i (issue_valid_i),
		.issue_tag_i   (issue_tag_i),
		.issue_op_i    (issue_op_i),
		.issue_prec_i  (issue_prec_i),
		.issue_a_i     (issue_a_i),
		.issue_b_i     (issue_b_i),
		.issue_t_i     (issue_t_i),
		.stomp_i       (stomp_i),
		.lane_mask_i   (lane_mask),
		.zero_fill_i   (zero_fill),
		.out_o         (s1_if.src)
	);

	fpu_lane_exec u_exec (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.stomp_i  (stomp_i),
		.in_i     (s1_if.snk),
		.out_o    (s2_if.src)
	);

	fpu_lane_merge u_merge (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.stomp_i     (stomp_i),
		.in_i        (s2_if.snk),
		.res_valid_o (res_valid_o),
		.res_tag_o   (res_tag_o),
		.res_data_o  (res_data_o),
		.res_we_o    (res_we_o),
		.res_exc_o   (res_exc_o),
		.exc_pulse_o (exc_pulse)
	);

endmodule

// File: rtl/fpu_lane_merge.sv
// FPU byte merge stage
`timescale 1ns/1ps

module fpu_lane_merge (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  lane_fpu_pkg::stomp_t     stomp_i,
	lane_op_if.snk                   in_i,
	output logic                     res_valid_o,
	output lane_fpu_pkg::tag_t       res_tag_o,
	output lane_fpu_pkg::fdata_t     res_data_o,
	output lane_fpu_pkg::bytemask_t  res_we_o,
	output logic                     res_exc_o,
	output logic                     exc_pulse_o
);
	import lane_fpu_pkg::*;

	fdata_t merged;
	logic   take;

	// ==============================
	// Byte merge
	// ==============================

	// Masked bytes come from the target register, or read as zero when
	// zero-fill is on; unmasked bytes carry the lane result
	always_comb begin
		for (int i = 0; i < BYTES; i++) begin
			if (in_i.lane_mask[i])
				merged[i*BYTE_W +: BYTE_W] = in_i.zfill ? '0 : in_i.t[i*BYTE_W +: BYTE_W];
			else
				merged[i*BYTE_W +: BYTE_W] = in_i.res[i*BYTE_W +: BYTE_W];
		end
	end

	// Last chance to cancel, a late stomp still removes the item here
	assign take = in_i.valid & ~stomp_i[in_i.tag];

	// ==============================
	// Output registers
	// ==============================
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			res_valid_o <= 1'b0;
			res_we_o <= '0;
			res_exc_o <= 1'b0;
		end else begin
			res_valid_o <= take;
			// All bytes are written, masked ones just carry t or zero
			res_we_o <= {BYTES{take}};
			res_exc_o <= take & in_i.exc;
		end
	end

	always_ff @(posedge clk) begin
		res_tag_o <= in_i.tag;
		res_data_o <= merged;
	end

	// One pulse per faulting result, the register block makes it sticky
	assign exc_pulse_o = res_exc_o;

	// The rename stage may only see write enables with a live result
	a_we_needs_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
		!res_valid_o |-> (res_we_o == '0));

endmodule

// File: rtl/fpu_lane_exec.sv
// FPU lane execution stage
`timescale 1ns/1ps

module fpu_lane_exec (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  lane_fpu_pkg::stomp_t  stomp_i,
	lane_op_if.snk                in_i,
	lane_op_if.src                out_o
);
	import lane_fpu_pkg::*;

	fdata_t prec_res [NUM_PREC];
	logic   prec_inv [NUM_PREC];
	fdata_t lane_res;
	logic   lane_exc;
	logic   is_cmp;

	// Lanes are shifted up so the sign is always bit 63 and the
	// unused low bits are zero, one set of helpers then serves all widths
	function automatic logic is_nan(fdata_t x, fdata_t exp_m);
		return ((x & exp_m) == exp_m) && ((x[DATA_W-2:0] & ~exp_m[DATA_W-2:0]) != '0);
	endfunction

	// Sign-magnitude order, so -0 is below +0
	function automatic logic sm_less(fdata_t x, fdata_t y);
		if (x[DATA_W-1] != y[DATA_W-1])
			return x[DATA_W-1];
		else if (x[DATA_W-1])
			return x[DATA_W-2:0] > y[DATA_W-2:0];
		else
			return x[DATA_W-2:0] < y[DATA_W-2:0];
	endfunction

	function automatic fdata_t lane_calc(fdata_t a, fdata_t b, fop_e op, logic nan);
		fdata_t r;
		case (op)
			FOP_NEG:  r = {~a[DATA_W-1], a[DATA_W-2:0]};
			FOP_ABS:  r = {1'b0, a[DATA_W-2:0]};
			FOP_SGNJ: r = {b[DATA_W-1], a[DATA_W-2:0]};
			// A NaN on either side leaves operand a in place
			FOP_MIN:  r = (!nan && sm_less(b, a)) ? b : a;
			FOP_MAX:  r = (!nan && sm_less(a, b)) ? b : a;
			default:  r = a;
		endcase
		return r;
	endfunction

	assign is_cmp = (in_i.op == FOP_MIN) || (in_i.op == FOP_MAX);

	// ==============================
	// Lanes for every precision
	// ==============================
	for (genvar p = 0; p < NUM_PREC; p++) begin : g_prec
		localparam int W = 16 << p;
		localparam int NL = DATA_W / W;
		localparam fdata_t EXP_M = (p == 0) ? EXP_MASK_H : (p == 1) ? EXP_MASK_S : EXP_MASK_D;
		wire [DATA_W-1:0] res_v;
		wire [NL-1:0]     inv_v;
		for (genvar l = 0; l < NL; l++) begin : g_lane
			fdata_t la;
			fdata_t lb;
			fdata_t lr;
			logic   nan;
			assign la = fdata_t'(in_i.a[l*W +: W]) << (DATA_W - W);
			assign lb = fdata_t'(in_i.b[l*W +: W]) << (DATA_W - W);
			assign nan = is_nan(la, EXP_M) | is_nan(lb, EXP_M);
			assign lr = lane_calc(la, lb, in_i.op, nan);
			assign res_v[l*W +: W] = lr[DATA_W-1 -: W];
			// Invalid is only raised by the compare operations
			assign inv_v[l] = nan & is_cmp;
		end
		assign prec_res[p] = res_v;
		assign prec_inv[p] = |inv_v;
	end

	// Pick the precision of this item, the reserved code acts as double
	always_comb begin
		case (in_i.prec)
			PREC_H: begin
				lane_res = prec_res[0];
				lane_exc = prec_inv[0];
			end
			PREC_S: begin
				lane_res = prec_res[1];
				lane_exc = prec_inv[1];
			end
			default: begin
				lane_res = prec_res[2];
				lane_exc = prec_inv[2];
			end
		endcase
	end

	// ==============================
	// Stage register
	// ==============================
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			out_o.valid <= 1'b0;
			out_o.exc <= 1'b0;
		end else begin
			out_o.valid <= in_i.valid & ~stomp_i[in_i.tag];
			out_o.exc <= lane_exc;
		end
	end

	always_ff @(posedge clk) begin
		out_o.tag <= in_i.tag;
		out_o.op <= in_i.op;
		out_o.prec <= in_i.prec;
		out_o.a <= in_i.a;
		out_o.b <= in_i.b;
		out_o.t <= in_i.t;
		out_o.lane_mask <= in_i.lane_mask;
		out_o.zfill <= in_i.zfill;
		out_o.res <= lane_res;
	end

endmodule

// File: rtl/fpu_issue_stage.sv
// FPU issue stage
`timescale 1ns/1ps

module fpu_issue_stage (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     issue_valid_i,
	input  lane_fpu_pkg::tag_t       issue_tag_i,
	input  lane_fpu_pkg::fop_e       issue_op_i,
	input  lane_fpu_pkg::prec_e      issue_prec_i,
	input  lane_fpu_pkg::fdata_t     issue_a_i,
	input  lane_fpu_pkg::fdata_t     issue_b_i,
	input  lane_fpu_pkg::fdata_t     issue_t_i,
	input  lane_fpu_pkg::stomp_t     stomp_i,
	input  lane_fpu_pkg::bytemask_t  lane_mask_i,
	input  logic                     zero_fill_i,
	lane_op_if.src                   out_o
);
	import lane_fpu_pkg::*;

	logic kill;

	// An operation whose tag is being cancelled right now never enters
	assign kill = stomp_i[issue_tag_i];

	// ==============================
	// Valid bit
	// ==============================
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			out_o.valid <= 1'b0;
		else
			out_o.valid <= issue_valid_i & ~kill;
	end

	// ==============================
	// Operation payload
	// ==============================

	// Operands are captured every cycle, the valid bit qualifies them
	// The lane mask and zero-fill setting are frozen here, so a later
	// register write cannot change an operation already in flight
	always_ff @(posedge clk) begin
		out_o.tag <= issue_tag_i;
		out_o.op <= issue_op_i;
		out_o.prec <= issue_prec_i;
		out_o.a <= issue_a_i;
		out_o.b <= issue_b_i;
		out_o.t <= issue_t_i;
		out_o.lane_mask <= lane_mask_i;
		out_o.zfill <= zero_fill_i;
	end

	// Nothing has been computed yet at this point
	assign out_o.exc = 1'b0;
	assign out_o.res = '0;

	// The scheduler must hand over a defined opcode with each operation
	a_op_known: assert property (@(posedge clk) disable iff (!arst_n_i)
		issue_valid_i |-> !$isunknown(issue_op_i));

endmodule

// File: rtl/fpu_ctrl_apb.sv
// FPU control registers
`timescale 1ns/1ps

module fpu_ctrl_apb (
	input  logic                                  clk,
	input  logic                                  arst_n_i,
	input  logic [lane_fpu_pkg::APB_ADDR_W-1:0]   paddr_i,
	input  logic                                  psel_i,
	input  logic                                  penable_i,
	input  logic                                  pwrite_i,
	input  logic [31:0]                           pwdata_i,
	input  logic                                  exc_pulse_i,
	output logic [31:0]                           prdata_o,
	output logic                                  pready_o,
	output logic                                  pslverr_o,
	output lane_fpu_pkg::bytemask_t               lane_mask_o,
	output logic                                  zero_fill_o
);
	import lane_fpu_pkg::*;

	logic access;
	logic wr_en;
	logic mapped;
	logic exc_q;

	// Zero wait states, every access completes in its first access cycle
	assign pready_o = 1'b1;
	assign access = psel_i & penable_i;
	assign wr_en = access & pwrite_i & mapped;
	assign pslverr_o = access & ~mapped;

	// Address decode shared by reads and writes
	always_comb begin
		mapped = 1'b1;
		prdata_o = '0;
		case (paddr_i)
			REG_LANE_MASK: prdata_o[BYTES-1:0] = lane_mask_o;
			REG_ZERO_FILL: prdata_o[0] = zero_fill_o;
			REG_EXC:       prdata_o[0] = exc_q;
			default:       mapped = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			lane_mask_o <= '0;
			zero_fill_o <= 1'b0;
			exc_q <= 1'b0;
		end else begin
			if (wr_en && paddr_i == REG_LANE_MASK)
				lane_mask_o <= pwdata_i[BYTES-1:0];
			if (wr_en && paddr_i == REG_ZERO_FILL)
				zero_fill_o <= pwdata_i[0];
			// Sticky flag, a new exception beats a clear in the same cycle
			if (exc_pulse_i)
				exc_q <= 1'b1;
			else if (wr_en && paddr_i == REG_EXC && pwdata_i[0])
				exc_q <= 1'b0;
		end
	end

	// The master must open every transfer with a setup phase
	a_penable_needs_psel: assert property (@(posedge clk) disable iff (!arst_n_i)
		penable_i |-> psel_i);

endmodule

// File: rtl/lane_op_if.sv
// Pipeline stage link
`timescale 1ns/1ps

interface lane_op_if;
	import lane_fpu_pkg::*;

	// Item qualifier and its reorder tag
	logic      valid;
	tag_t      tag;

	// Operation and lane split
	fop_e      op;
	prec_e     prec;

	// Source operands and the merge target
	fdata_t    a;
	fdata_t    b;
	fdata_t    t;

	// Control context captured at issue
	bytemask_t lane_mask;
	logic      zfill;

	// Lane results, only meaningful once the exec stage has run
	logic      exc;
	fdata_t    res;

	// Producing stage
	modport src (output valid, tag, op, prec, a, b, t, lane_mask, zfill, exc, res);

	// Consuming stage
	modport snk (input valid, tag, op, prec, a, b, t, lane_mask, zfill, exc, res);

endinterface

// File: rtl/lane_fpu_pkg.sv
// Lane FPU shared definitions
package lane_fpu_pkg;

	// ==============================
	// Datapath geometry
	// ==============================

	// Full operand width, one double or two singles or four halves
	localparam int DATA_W = 64;
	localparam int BYTE_W = 8;
	localparam int BYTES = DATA_W / BYTE_W;

	// Number of supported precisions, half, single and double
	localparam int NUM_PREC = 3;

	// Reorder tags and the matching stomp vector
	localparam int TAG_W = 3;
	localparam int TAGS = 1 << TAG_W;

	// APB register file addressing
	localparam int APB_ADDR_W = 4;

	typedef logic [DATA_W-1:0] fdata_t;
	typedef logic [BYTES-1:0]  bytemask_t;
	typedef logic [TAG_W-1:0]  tag_t;
	typedef logic [TAGS-1:0]   stomp_t;

	// Lane operations, unlisted codes pass operand a through
	typedef enum logic [2:0] {
		FOP_NEG  = 3'd0,
		FOP_ABS  = 3'd1,
		FOP_SGNJ = 3'd2,
		FOP_MIN  = 3'd3,
		FOP_MAX  = 3'd4
	} fop_e;

	// Lane precision, code 3 is reserved and handled as double
	typedef enum logic [1:0] {
		PREC_H = 2'd0,
		PREC_S = 2'd1,
		PREC_D = 2'd2
	} prec_e;

	// Exponent field masks for a lane that has been shifted up to bit 63
	// Sign sits at bit 63, the exponent follows right below it
	localparam fdata_t EXP_MASK_H = 64'h7C00_0000_0000_0000;
	localparam fdata_t EXP_MASK_S = 64'h7F80_0000_0000_0000;
	localparam fdata_t EXP_MASK_D = 64'h7FF0_0000_0000_0000;

	// ==============================
	// APB register map
	// ==============================
	localparam logic [APB_ADDR_W-1:0] REG_LANE_MASK = 4'h0;
	localparam logic [APB_ADDR_W-1:0] REG_ZERO_FILL = 4'h4;
	localparam logic [APB_ADDR_W-1:0] REG_EXC       = 4'h8;

endpackage
